//--- rtl/tr_pkg.sv
`default_nettype none

package tr_pkg;

    // clocks in one bit time, one per phase
    localparam int unsigned PHASES_PER_BIT = 4;

    // bit positions inside the one-hot phase vector
    localparam int unsigned PH_W6 = 0; // command sampling
    localparam int unsigned PH_X8 = 1; // register action
    localparam int unsigned PH_Y4 = 2;
    localparam int unsigned PH_Z2 = 3; // delayed copy

endpackage

`default_nettype wire

//--- rtl/phase_timer.sv
`timescale 1ns/1ns
`default_nettype none

module phase_timer (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    output logic [tr_pkg::PHASES_PER_BIT-1:0]        phase,
    output logic                                     bit_start
);

    localparam int unsigned CNT_W = $clog2(tr_pkg::PHASES_PER_BIT);

    logic [CNT_W-1:0] cnt;

    // the counter starts at w6 so a bit time opens right after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(tr_pkg::PHASES_PER_BIT - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // count value equals the phase index
    always_comb begin
        phase = '0;
        phase[tr_pkg::PH_W6] = (cnt == CNT_W'(tr_pkg::PH_W6));
        phase[tr_pkg::PH_X8] = (cnt == CNT_W'(tr_pkg::PH_X8));
        phase[tr_pkg::PH_Y4] = (cnt == CNT_W'(tr_pkg::PH_Y4));
        phase[tr_pkg::PH_Z2] = (cnt == CNT_W'(tr_pkg::PH_Z2));
    end

    assign bit_start = phase[tr_pkg::PH_W6]; // one cycle per bit time

    // the phases must walk w6, x8, y4, z2 with exactly one active
    a_phase_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(phase)
    );

endmodule

`default_nettype wire

//--- rtl/buffer_regs.sv
`timescale 1ns/1ns
`default_nettype none

module buffer_regs #(
    parameter int unsigned TR_WIDTH = 9
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                wr_en,
    input  wire logic                wr_sel,
    input  wire logic [TR_WIDTH-1:0] wr_data,
    input  wire logic                load_sel,
    output logic      [TR_WIDTH-1:0] load_word
);

    logic [TR_WIDTH-1:0] buf_a;
    logic [TR_WIDTH-1:0] buf_b;

    // wr_sel low picks buffer A, high picks buffer B
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_a <= '0;
            buf_b <= '0;
        end else if (wr_en) begin
            if (wr_sel) begin
                buf_b <= wr_data;
            end else begin
                buf_a <= wr_data;
            end
        end
    end

    // the register only ever sees one parallel source
    always_comb begin
        if (load_sel) begin
            load_word = buf_b;
        end else begin
            load_word = buf_a;
        end
    end

endmodule

`default_nettype wire

//--- rtl/transfer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module transfer_ctrl (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [tr_pkg::PHASES_PER_BIT-1:0]   phase,
    input  wire logic                                cmd_clear,
    input  wire logic                                cmd_exch,
    input  wire logic                                cmd_load,
    input  wire logic                                cmd_shift,
    output logic                                     do_clear,
    output logic                                     do_exch,
    output logic                                     do_load,
    output logic                                     do_shift
);

    logic nxt_clear;
    logic nxt_exch;
    logic nxt_load;
    logic nxt_shift;

    // priority resolution of the command levels
    // exch only modifies a clear, on its own it selects nothing
    always_comb begin
        nxt_clear = 1'b0;
        nxt_exch  = 1'b0;
        nxt_load  = 1'b0;
        nxt_shift = 1'b0;
        if (cmd_clear) begin
            if (cmd_exch) begin
                nxt_exch = 1'b1; // clear that spares the middle bits
            end else begin
                nxt_clear = 1'b1;
            end
        end else if (cmd_load) begin
            nxt_load = 1'b1;
        end else if (cmd_shift) begin
            nxt_shift = 1'b1;
        end
    end

    // sampled once per bit time and held until the next w6
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            do_clear <= 1'b0;
            do_exch  <= 1'b0;
            do_load  <= 1'b0;
            do_shift <= 1'b0;
        end else if (phase[tr_pkg::PH_W6]) begin
            do_clear <= nxt_clear;
            do_exch  <= nxt_exch;
            do_load  <= nxt_load;
            do_shift <= nxt_shift;
        end
    end

    // the register acts on at most one strobe per bit time
    a_strobe_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({do_clear, do_exch, do_load, do_shift})
    );

endmodule

`default_nettype wire

//--- rtl/transfer_reg.sv
`timescale 1ns/1ns
`default_nettype none

module transfer_reg #(
    parameter int unsigned TR_WIDTH = 9,
    parameter int unsigned KEEP_LO  = 4,
    parameter int unsigned KEEP_HI  = 7
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [tr_pkg::PHASES_PER_BIT-1:0]   phase,
    input  wire logic                                do_clear,
    input  wire logic                                do_exch,
    input  wire logic                                do_load,
    input  wire logic                                do_shift,
    input  wire logic                                din,
    input  wire logic [TR_WIDTH-1:0]                 load_word,
    output logic      [TR_WIDTH-1:0]                 tr,
    output logic      [TR_WIDTH-1:0]                 tr_d,
    output logic                                     dout,
    output logic                                     full
);

    logic [TR_WIDTH-1:0] keep_mask;
    logic [TR_WIDTH-1:0] tr_next;
    logic                dout_next;

    // bits that survive an exchange-clear
    for (genvar i = 0; i < TR_WIDTH; i++) begin : g_keep
        assign keep_mask[i] = (i >= KEEP_LO) && (i <= KEEP_HI);
    end

    // next word for the x8 edge
    always_comb begin
        tr_next   = tr;
        dout_next = dout;
        if (do_clear) begin
            tr_next = '0;
        end else if (do_exch) begin
            tr_next = tr & keep_mask;
        end else if (do_load) begin
            tr_next = load_word;
        end else if (do_shift) begin
            // shift toward the msb, the old msb leaves on dout
            tr_next   = {tr[TR_WIDTH-2:0], din};
            dout_next = tr[TR_WIDTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tr   <= '0;
            dout <= 1'b0;
        end else if (phase[tr_pkg::PH_X8]) begin
            tr   <= tr_next;
            dout <= dout_next; // holds the last bit shifted out
        end
    end

    // delayed copy of the word, taken late in the bit time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tr_d <= '0;
        end else if (phase[tr_pkg::PH_Z2]) begin
            tr_d <= tr;
        end
    end

    assign full = &tr;

    // tr may only move on the edge that closes an x8 cycle
    a_tr_x8_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && (tr != $past(tr))) |-> $past(phase[tr_pkg::PH_X8])
    );

endmodule

`default_nettype wire

//--- rtl/transfer_unit.sv
`timescale 1ns/1ns
`default_nettype none

module transfer_unit #(
    parameter int unsigned TR_WIDTH = 9,
    parameter int unsigned KEEP_LO  = 4,
    parameter int unsigned KEEP_HI  = 7
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                din,
    input  wire logic                cmd_clear,
    input  wire logic                cmd_exch,
    input  wire logic                cmd_load,
    input  wire logic                load_sel,
    input  wire logic                cmd_shift,
    input  wire logic                buf_wr_en,
    input  wire logic                buf_wr_sel,
    input  wire logic [TR_WIDTH-1:0] buf_wr_data,
    output logic      [TR_WIDTH-1:0] tr,
    output logic      [TR_WIDTH-1:0] tr_d,
    output logic                     dout,
    output logic                     full,
    output logic                     bit_start
);

    logic [tr_pkg::PHASES_PER_BIT-1:0] phase;
    logic [TR_WIDTH-1:0]               load_word;
    logic                              do_clear;
    logic                              do_exch;
    logic                              do_load;
    logic                              do_shift;

    phase_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .bit_start (bit_start)
    );

    buffer_regs #(
        .TR_WIDTH (TR_WIDTH)
    ) u_buffers (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (buf_wr_en),
        .wr_sel    (buf_wr_sel),
        .wr_data   (buf_wr_data),
        .load_sel  (load_sel),
        .load_word (load_word)
    );

    // one action per bit time, chosen at w6
    transfer_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .cmd_clear (cmd_clear),
        .cmd_exch  (cmd_exch),
        .cmd_load  (cmd_load),
        .cmd_shift (cmd_shift),
        .do_clear  (do_clear),
        .do_exch   (do_exch),
        .do_load   (do_load),
        .do_shift  (do_shift)
    );

    transfer_reg #(
        .TR_WIDTH (TR_WIDTH),
        .KEEP_LO  (KEEP_LO),
        .KEEP_HI  (KEEP_HI)
    ) u_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .do_clear  (do_clear),
        .do_exch   (do_exch),
        .do_load   (do_load),
        .do_shift  (do_shift),
        .din       (din),
        .load_word (load_word),
        .tr        (tr),
        .tr_d      (tr_d),
        .dout      (dout),
        .full      (full)
    );

endmodule

`default_nettype wire

//--- tests/tr_ref_model.svh
`ifndef TR_REF_MODEL_SVH
`define TR_REF_MODEL_SVH

// one bit time of the transfer register, worked out from the command levels
// returns the word after x8, with dout and full through the output arguments
function automatic logic [TR_WIDTH-1:0] ref_step(
    input  logic [TR_WIDTH-1:0] prev,
    input  logic                prev_dout,
    input  logic                clr,
    input  logic                exch,
    input  logic                ld,
    input  logic                sel,
    input  logic                sh,
    input  logic                d,
    input  logic [TR_WIDTH-1:0] word_a,
    input  logic [TR_WIDTH-1:0] word_b,
    output logic                next_dout,
    output logic                next_full
);
    logic [TR_WIDTH-1:0] word;
    word      = prev;
    next_dout = prev_dout; // dout only moves when a bit is shifted out
    if (clr) begin
        word = '0;
        // exchange-clear is a clear that spares the middle field
        if (exch) begin
            for (int i = KEEP_LO; i <= KEEP_HI; i++) begin
                word[i] = prev[i];
            end
        end
    end else if (ld) begin
        word = sel ? word_b : word_a;
    end else if (sh) begin
        word      = (prev << 1) | TR_WIDTH'(d);
        next_dout = prev[TR_WIDTH-1];
    end
    next_full = (word == {TR_WIDTH{1'b1}});
    return word;
endfunction

`endif

//--- tests/tb_transfer_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_transfer_unit;

    localparam int TR_WIDTH = 9;
    localparam int KEEP_LO  = 4;
    localparam int KEEP_HI  = 7;
    localparam int NUM_BITS = 64; // about 47 bit times are driven, the rest is margin

    logic                clk;
    logic                rst_n;
    logic                din;
    logic                cmd_clear;
    logic                cmd_exch;
    logic                cmd_load;
    logic                load_sel;
    logic                cmd_shift;
    logic                buf_wr_en;
    logic                buf_wr_sel;
    logic [TR_WIDTH-1:0] buf_wr_data;
    logic [TR_WIDTH-1:0] tr;
    logic [TR_WIDTH-1:0] tr_d;
    logic                dout;
    logic                full;
    logic                bit_start;

    `include "tr_ref_model.svh"

    // model state, advanced once per driven bit time
    logic [TR_WIDTH-1:0] m_tr;
    logic                m_dout;
    logic [TR_WIDTH-1:0] m_buf_a;
    logic [TR_WIDTH-1:0] m_buf_b;

    // expectations for the coming bit_start samples, oldest first
    logic [TR_WIDTH-1:0] exp_tr_q[$];
    logic [TR_WIDTH-1:0] exp_trd_q[$];
    logic                exp_dout_q[$];
    logic                exp_full_q[$];

    logic [TR_WIDTH-1:0] e_tr;
    logic [TR_WIDTH-1:0] e_trd;
    logic                e_dout;
    logic                e_full;
    logic                e_start;
    int unsigned         cyc_count;
    logic [TR_WIDTH-1:0] rand_a;
    logic [TR_WIDTH-1:0] rand_b;
    logic [31:0]         rnd;
    integer              seed;
    int                  err_count;
    int                  test_err_start;
    int                  tests_passed;
    int                  tests_failed;

    transfer_unit #(
        .TR_WIDTH (TR_WIDTH),
        .KEEP_LO  (KEEP_LO),
        .KEEP_HI  (KEEP_HI)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .din         (din),
        .cmd_clear   (cmd_clear),
        .cmd_exch    (cmd_exch),
        .cmd_load    (cmd_load),
        .load_sel    (load_sel),
        .cmd_shift   (cmd_shift),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_sel  (buf_wr_sel),
        .buf_wr_data (buf_wr_data),
        .tr          (tr),
        .tr_d        (tr_d),
        .dout        (dout),
        .full        (full),
        .bit_start   (bit_start)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic push_expect(input logic [TR_WIDTH-1:0] word, input logic d,
                               input logic f);
        exp_tr_q.push_back(word);
        exp_trd_q.push_back(word); // z2 copies the word written in x8 of the same bit time
        exp_dout_q.push_back(d);
        exp_full_q.push_back(f);
    endtask

    // drives the command levels for the current bit time and predicts its outcome
    task automatic drive_bit(input logic clr, input logic exch, input logic ld,
                             input logic sel, input logic sh, input logic d);
        logic [TR_WIDTH-1:0] next_word;
        logic                next_dout;
        logic                next_full;
        cmd_clear = clr;
        cmd_exch  = exch;
        cmd_load  = ld;
        load_sel  = sel;
        cmd_shift = sh;
        din       = d;
        next_word = ref_step(m_tr, m_dout, clr, exch, ld, sel, sh, d, m_buf_a, m_buf_b,
                             next_dout, next_full);
        push_expect(next_word, next_dout, next_full);
        m_tr   = next_word;
        m_dout = next_dout;
    endtask

    task automatic wait_bit_start();
        do begin
            @(posedge clk);
            #1;
        end while (!bit_start);
    endtask

    task automatic run_bit(input logic clr, input logic exch, input logic ld,
                           input logic sel, input logic sh, input logic d);
        wait_bit_start();
        drive_bit(clr, exch, ld, sel, sh, d);
    endtask

    task automatic idle_bit();
        run_bit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // both buffers are written inside one idle bit time
    task automatic write_buffers(input logic [TR_WIDTH-1:0] a, input logic [TR_WIDTH-1:0] b);
        idle_bit();
        buf_wr_en   = 1'b1;
        buf_wr_sel  = 1'b0;
        buf_wr_data = a;
        @(posedge clk);
        #1;
        buf_wr_sel  = 1'b1;
        buf_wr_data = b;
        @(posedge clk);
        #1;
        buf_wr_en = 1'b0;
        m_buf_a   = a;
        m_buf_b   = b;
    endtask

    // one more bit time so the last action gets compared
    task automatic settle();
        idle_bit();
        @(negedge clk);
        #1;
    endtask

    task automatic report_test(input string name);
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - test_err_start);
        end
        test_err_start = err_count;
    endtask

    // every bit_start sample is held against the prediction of the previous bit time
    always @(negedge clk) begin
        if (!rst_n) begin
            cyc_count = 0;
        end else begin
            // w6 comes first after reset and then every PHASES_PER_BIT cycles
            e_start = (cyc_count % tr_pkg::PHASES_PER_BIT) == 0;
            assert (bit_start === e_start) else begin
                $display("Error: bit_start expected %h got %h", e_start, bit_start);
                err_count++;
            end
            if (bit_start) begin
                if (exp_tr_q.size() == 0) begin
                    $display("no prediction was queued for the sample at %0t ns", $time);
                    err_count++;
                end else begin
                    e_tr   = exp_tr_q.pop_front();
                    e_trd  = exp_trd_q.pop_front();
                    e_dout = exp_dout_q.pop_front();
                    e_full = exp_full_q.pop_front();
                    assert (tr === e_tr) else begin
                        $display("Error: tr expected %h got %h", e_tr, tr);
                        err_count++;
                    end
                    assert (tr_d === e_trd) else begin
                        $display("Error: tr_d expected %h got %h", e_trd, tr_d);
                        err_count++;
                    end
                    assert (dout === e_dout) else begin
                        $display("Error: dout expected %h got %h", e_dout, dout);
                        err_count++;
                    end
                    assert (full === e_full) else begin
                        $display("Error: full expected %h got %h", e_full, full);
                        err_count++;
                    end
                end
            end
            // in z2 tr has moved already while tr_d still holds the word of the last sample
            if ((cyc_count % tr_pkg::PHASES_PER_BIT) == tr_pkg::PHASES_PER_BIT - 1) begin
                assert (tr_d === e_tr) else begin
                    $display("Error: tr_d expected %h got %h before the z2 copy", e_tr, tr_d);
                    err_count++;
                end
            end
            cyc_count++;
        end
    end

    initial begin
        repeat (NUM_BITS * tr_pkg::PHASES_PER_BIT + 100) @(posedge clk);
        $display("timeout: the tests did not complete within the expected number of cycles");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        din            = 1'b0;
        cmd_clear      = 1'b0;
        cmd_exch       = 1'b0;
        cmd_load       = 1'b0;
        load_sel       = 1'b0;
        cmd_shift      = 1'b0;
        buf_wr_en      = 1'b0;
        buf_wr_sel     = 1'b0;
        buf_wr_data    = '0;
        m_tr           = '0;
        m_dout         = 1'b0;
        m_buf_a        = '0;
        m_buf_b        = '0;
        seed           = 58;
        err_count      = 0;
        test_err_start = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        push_expect('0, 1'b0, 1'b0); // everything is zero out of reset

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1; // the first w6 cycle opens here

        drive_bit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        settle();
        report_test("reset values");

        rand_a = TR_WIDTH'($random(seed));
        rand_b = TR_WIDTH'($random(seed));
        write_buffers(rand_a, rand_b);
        idle_bit();
        run_bit(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_bit(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        settle();
        report_test("parallel load");

        for (int i = 0; i < TR_WIDTH; i++) begin
            rnd = $random(seed);
            run_bit(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, rnd[0]);
        end
        // nine ones fill the register completely
        for (int i = 0; i < TR_WIDTH; i++) begin
            run_bit(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        end
        settle();
        assert (full === 1'b1) else begin
            $display("Error: full expected %h got %h", 1'b1, full);
            err_count++;
        end
        report_test("serial shift");

        run_bit(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run_bit(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        rand_a = TR_WIDTH'($random(seed));
        rand_b = TR_WIDTH'($random(seed));
        write_buffers(rand_a, rand_b);
        idle_bit();
        run_bit(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_bit(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run_bit(1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1); // clear beats load and shift
        settle();
        report_test("clear and exchange-clear");

        // mixed commands, tr_d is compared on every sample
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            run_bit(rnd[3:0] == 4'd0, rnd[4], rnd[6:5] == 2'd0, rnd[7], rnd[8], rnd[9]);
        end
        settle();
        report_test("delayed copy");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: transfer_unit

sources:
  - rtl/tr_pkg.sv
  - rtl/phase_timer.sv
  - rtl/buffer_regs.sv
  - rtl/transfer_ctrl.sv
  - rtl/transfer_reg.sv
  - rtl/transfer_unit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_transfer_unit.sv

//--- tb.f
+incdir+tests
rtl/tr_pkg.sv
rtl/phase_timer.sv
rtl/buffer_regs.sv
rtl/transfer_ctrl.sv
rtl/transfer_reg.sv
rtl/transfer_unit.sv
tests/tb_transfer_unit.sv
